// ==== hw/life_pkg.sv ====
// Game of Life grid geometry, rule pipeline and seed LFSR definitions
// Shared by the sequencer, cell banks and seed generator

package life_pkg;

	// Grid geometry, toroidal
	localparam int GRID_W   = 16; // Columns, also row word width
	localparam int GRID_H   = 16; // Rows
	localparam int ROW_BITS = 4;  // Row index width

	// Read address to next-row output
	// Stage 1 fetches three rows, stage 2 applies the rule
	localparam int RULE_LAT = 2;

	// Seed generator, one LFSR state per grid row
	localparam int LFSR_W = 16;
	localparam logic [LFSR_W-1:0] LFSR_SEED = 16'hB058; // Any nonzero start
	// x^16+x^14+x^13+x^11+1, right shift form taps bits 0,2,3,5
	localparam logic [LFSR_W-1:0] LFSR_TAPS = 16'h002D;

	// One grid row, bit n is column n
	typedef logic [GRID_W-1:0] row_t;

	// Row address
	typedef logic [ROW_BITS-1:0] row_idx_t;

endpackage

// ==== hw/ctrl_pkg.sv ====
// Control timing for the fire button, power-up seeding and rate window
// Counter widths follow from each limit

package ctrl_pkg;

	// Button debounce, in clk4 cycles
	localparam int DB_PRESS   = 16;  // Stable high before a step
	localparam int DB_LONG    = 256; // Held this long enters run mode
	localparam int DB_RELEASE = 32;  // Stable low before back to idle
	localparam int DB_CNT_W   = $clog2(DB_LONG);
	localparam int REL_CNT_W  = $clog2(DB_RELEASE);

	// Power-up, quiet time then one seed row per cycle
	localparam int INIT_WAIT  = 64;
	localparam int INIT_DONE  = INIT_WAIT + life_pkg::GRID_H;
	localparam int INIT_CNT_W = $clog2(INIT_DONE + 1);

	// Generation statistics
	localparam int RATE_WINDOW = 1024; // Rate measurement window
	localparam int RATE_CNT_W  = $clog2(RATE_WINDOW);
	localparam int COUNT_W     = 32;   // Total generations
	localparam int RATE_W      = 16;   // Generations per window

endpackage

// ==== hw/stage_delay.sv ====
// Fixed depth delay line, any payload type
// Used to line up write address and enable with the rule pipeline

module stage_delay #(
	parameter int  DEPTH     = 2,
	parameter type payload_t = logic
) (
	input  logic     clk4,
	input  logic     reset,
	input  payload_t din,
	output payload_t dout
);

	payload_t pipe [DEPTH]; // pipe[0] is the newest

	always_ff @(posedge clk4) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				pipe[i] <= '0;
			end
		end else begin
			pipe[0] <= din;
			for (int i = 1; i < DEPTH; i++) begin
				pipe[i] <= pipe[i-1]; // Shift one stage
			end
		end
	end

	assign dout = pipe[DEPTH-1];

endmodule

// ==== hw/button_debounce.sv ====
// Fire button debounce
// Short press gives a one-cycle step, a long hold gives run until release

module button_debounce (
	input  logic clk4,
	input  logic reset,
	input  logic fire_button,
	output logic step,
	output logic run
);

	typedef enum logic [2:0] {
		st_idle,
		st_wait_press, // Pressed, not yet stable
		st_wait_long,  // Step issued, waiting for long hold
		st_long,       // Run mode
		st_wait_off,   // Released after short press
		st_wait_loff   // Released after long hold, run still on
	} state_t;

	state_t                           state;
	logic [1:0]                       sync; // Button is asynchronous
	logic                             btn;
	logic [ctrl_pkg::DB_CNT_W-1:0]   press_cnt;
	logic [ctrl_pkg::REL_CNT_W-1:0]  rel_cnt;

	always_ff @(posedge clk4) begin
		if (reset) begin
			sync <= '0;
		end else begin
			sync <= {sync[0], fire_button};
		end
	end
	assign btn = sync[1];

	////////////////////////////////////////////////////////////
	// Press/hold state machine

	always_ff @(posedge clk4) begin
		if (reset) begin
			state <= st_idle;
			step  <= 1'b0;
		end else begin
			step <= 1'b0;
			case (state)
				st_idle       : if (btn) state <= st_wait_press;
				st_wait_press : begin
					if (!btn) begin
						state <= st_idle; // Glitch, drop it
					end else if (press_cnt == ctrl_pkg::DB_PRESS - 1) begin
						state <= st_wait_long;
						step  <= 1'b1;    // Single generation
					end
				end
				st_wait_long  : begin
					if (!btn) state <= st_wait_off;
					else if (press_cnt == ctrl_pkg::DB_LONG - 1) state <= st_long;
				end
				st_long       : if (!btn) state <= st_wait_loff;
				st_wait_off   : begin
					if (btn) state <= st_wait_long; // Bounce, keep timing hold
					else if (rel_cnt == ctrl_pkg::DB_RELEASE - 1) state <= st_idle;
				end
				st_wait_loff  : begin
					if (btn) state <= st_long;
					else if (rel_cnt == ctrl_pkg::DB_RELEASE - 1) state <= st_idle;
				end
				default       : state <= st_idle;
			endcase
		end
	end

	// Hold and release counters
	always_ff @(posedge clk4) begin
		if (reset) begin
			press_cnt <= '0;
			rel_cnt   <= '0;
		end else begin
			if (state == st_idle) press_cnt <= '0;
			else if (state == st_wait_press || state == st_wait_long) press_cnt <= press_cnt + 1'b1;
			if ((state == st_wait_off || state == st_wait_loff) && !btn) begin
				rel_cnt <= rel_cnt + 1'b1;
			end else begin
				rel_cnt <= '0; // Any high sample restarts release timing
			end
		end
	end

	assign run = (state == st_long) || (state == st_wait_loff);

	// Step only comes early in a press, run only after DB_LONG
	a_step_not_run: assert property (@(posedge clk4) disable iff (reset) !(step && run))
		else $error("step and run high together");

endmodule

// ==== hw/seed_lfsr.sv ====
// Seed row generator
// Fibonacci LFSR, one step and one grid row per seed_adv

module seed_lfsr (
	input  logic           clk4,
	input  logic           reset,
	input  logic           seed_adv,
	output life_pkg::row_t seed_row
);

	logic [life_pkg::LFSR_W-1:0] lfsr;
	logic [life_pkg::LFSR_W-1:0] lfsr_next;

	// Shift toward bit 0, parity of tapped bits enters at the top
	assign lfsr_next = {^(lfsr & life_pkg::LFSR_TAPS), lfsr[life_pkg::LFSR_W-1:1]};

	always_ff @(posedge clk4) begin
		if (reset) begin
			lfsr <= life_pkg::LFSR_SEED; // Must not be zero
		end else if (seed_adv) begin
			lfsr <= lfsr_next;
		end
	end

	// Row is the state after this cycle's step
	// so it is written in the same cycle that seed_adv is high
	assign seed_row = lfsr_next;

endmodule

// ==== hw/gen_sequencer.sv ====
// Generation sequencer
// Power-up seeding, row walk per generation, write-back timing and bank swap

module gen_sequencer (
	input  logic               clk4,
	input  logic               reset,
	input  logic               step,
	input  logic               run,
	output logic               seed_adv,
	output life_pkg::row_idx_t rd_center,
	output logic               wr_en,
	output life_pkg::row_idx_t wr_row,
	output logic               wr_seed,
	output logic               bank_sel,
	output logic               ready,
	output logic               gen_done
);

	logic [ctrl_pkg::INIT_CNT_W-1:0] init_cnt;
	logic               seeded;    // Grid holds a valid generation
	life_pkg::row_idx_t seed_idx;
	logic               go;
	logic               start;
	logic               busy;      // From start to last write-back
	logic               reading;   // Row addresses being issued
	logic               gen_wr_en;
	life_pkg::row_idx_t gen_wr_row;
	logic               last_wr;

	////////////////////////////////////////////////////////////
	// Power-up seeding

	always_ff @(posedge clk4) begin
		if (reset) begin
			init_cnt <= '0;
		end else if (!seeded) begin
			init_cnt <= init_cnt + 1'b1; // Stops at INIT_DONE
		end
	end

	assign seeded   = (init_cnt == ctrl_pkg::INIT_DONE);
	assign seed_adv = (init_cnt >= ctrl_pkg::INIT_WAIT) && !seeded;
	assign seed_idx = life_pkg::row_idx_t'(init_cnt - ctrl_pkg::INIT_WAIT);

	////////////////////////////////////////////////////////////
	// Generation row walk

	assign go    = step | run;
	assign start = seeded & ~busy & go; // Ignored while busy

	always_ff @(posedge clk4) begin
		if (reset) begin
			busy      <= 1'b0;
			reading   <= 1'b0;
			rd_center <= '0;
			bank_sel  <= 1'b0; // Seed lands in bank 0
			gen_done  <= 1'b0;
		end else begin
			gen_done <= last_wr;
			if (start) begin
				busy      <= 1'b1;
				reading   <= 1'b1;
				rd_center <= '0;
			end else if (last_wr) begin
				busy     <= 1'b0;
				bank_sel <= ~bank_sel; // New generation becomes active
			end
			if (reading) begin
				if (rd_center == life_pkg::row_idx_t'(life_pkg::GRID_H - 1)) begin
					reading <= 1'b0;
				end else begin
					rd_center <= rd_center + 1'b1;
				end
			end
		end
	end

	// Address and enable follow the rule pipeline
	stage_delay #(
		.DEPTH     ( life_pkg::RULE_LAT  ),
		.payload_t ( life_pkg::row_idx_t )
	) _row_dly (
		.clk4  ( clk4       ),
		.reset ( reset      ),
		.din   ( rd_center  ),
		.dout  ( gen_wr_row )
	);

	stage_delay #(
		.DEPTH     ( life_pkg::RULE_LAT ),
		.payload_t ( logic              )
	) _en_dly (
		.clk4  ( clk4      ),
		.reset ( reset     ),
		.din   ( reading   ),
		.dout  ( gen_wr_en )
	);

	assign last_wr = gen_wr_en && (gen_wr_row == life_pkg::row_idx_t'(life_pkg::GRID_H - 1));

	// Write port, seed rows or rule output
	assign wr_en   = gen_wr_en | seed_adv;
	assign wr_row  = seed_adv ? seed_idx : gen_wr_row;
	assign wr_seed = seed_adv;

	// Stays low across back-to-back generations in run mode
	assign ready = seeded & ~busy & ~(gen_done & go);

	a_no_wr_ready: assert property (@(posedge clk4) disable iff (reset) wr_en |-> !ready)
		else $error("row write while ready");

endmodule

// ==== hw/cell_array.sv ====
// Cell banks and life rule engine
// Two ping-pong row banks, wrapped neighbor fetch, B3/S23 rule, row readout

module cell_array (
	input  logic               clk4,
	input  logic               reset,
	input  life_pkg::row_idx_t rd_center,
	input  logic               bank_sel,
	input  logic               wr_en,
	input  life_pkg::row_idx_t wr_row,
	input  logic               wr_seed,
	input  life_pkg::row_t     seed_row,
	input  logic               rd_req,
	input  life_pkg::row_idx_t rd_row,
	output life_pkg::row_t     rd_data
);

	life_pkg::row_t     mem [2][life_pkg::GRID_H]; // [bank][row]
	life_pkg::row_idx_t up_idx;
	life_pkg::row_idx_t dn_idx;
	life_pkg::row_t     up_q;   // Stage 1
	life_pkg::row_t     mid_q;
	life_pkg::row_t     dn_q;
	life_pkg::row_t     next_q; // Stage 2
	logic               wr_bank;
	life_pkg::row_t     wr_data;

	// B3/S23 on one row, columns wrap
	function automatic life_pkg::row_t life_rule(
		input life_pkg::row_t up,
		input life_pkg::row_t mid,
		input life_pkg::row_t dn
	);
		life_pkg::row_t res;
		int             cl;
		int             cr;
		logic [3:0]     cnt;
		res = '0;
		for (int c = 0; c < life_pkg::GRID_W; c++) begin
			cl  = (c + life_pkg::GRID_W - 1) % life_pkg::GRID_W;
			cr  = (c + 1) % life_pkg::GRID_W;
			cnt = 4'(up[cl]) + 4'(up[c]) + 4'(up[cr]) + 4'(mid[cl]) + 4'(mid[cr])
				+ 4'(dn[cl]) + 4'(dn[c]) + 4'(dn[cr]); // Center not counted
			res[c] = (cnt == 4'd3) || (mid[c] && cnt == 4'd2);
		end
		return res;
	endfunction

	// Row wrap, top neighbor of row 0 is the last row
	assign up_idx = (rd_center == '0) ? life_pkg::row_idx_t'(life_pkg::GRID_H - 1)
		: rd_center - 1'b1;
	assign dn_idx = (rd_center == life_pkg::row_idx_t'(life_pkg::GRID_H - 1)) ? '0
		: rd_center + 1'b1;

	////////////////////////////////////////////////////////////
	// Rule pipeline, RULE_LAT stages

	always_ff @(posedge clk4) begin
		up_q   <= mem[bank_sel][up_idx];
		mid_q  <= mem[bank_sel][rd_center];
		dn_q   <= mem[bank_sel][dn_idx];
		next_q <= life_rule(up_q, mid_q, dn_q);
	end

	// Write-back into the idle bank, seed always to bank 0
	assign wr_bank = wr_seed ? 1'b0 : ~bank_sel;
	assign wr_data = wr_seed ? seed_row : next_q;

	always_ff @(posedge clk4) begin
		if (wr_en) begin
			mem[wr_bank][wr_row] <= wr_data;
		end
	end

	// Readout, active bank only
	always_ff @(posedge clk4) begin
		if (reset) begin
			rd_data <= '0;
		end else if (rd_req) begin
			rd_data <= mem[bank_sel][rd_row];
		end
	end

	// Seed rows come with a write and only before the first bank swap
	a_seed_bank0: assert property (@(posedge clk4) disable iff (reset)
		wr_seed |-> (wr_en && !bank_sel))
		else $error("seed write outside power-up seeding");

endmodule

// ==== hw/gen_stats.sv ====
// Generation statistics
// Running total and generations per rate window

module gen_stats (
	input  logic                          clk4,
	input  logic                          reset,
	input  logic                          gen_done,
	output logic [ctrl_pkg::COUNT_W-1:0] gen_count,
	output logic [ctrl_pkg::RATE_W-1:0]  gen_rate,
	output logic                          rate_update
);

	logic [ctrl_pkg::RATE_CNT_W-1:0] win_cnt;  // Cycle within window
	logic [ctrl_pkg::RATE_W-1:0]     win_gens; // Generations so far this window

	always_ff @(posedge clk4) begin
		if (reset) begin
			gen_count   <= '0;
			gen_rate    <= '0;
			rate_update <= 1'b0;
			win_cnt     <= '0;
			win_gens    <= '0;
		end else begin
			if (gen_done) gen_count <= gen_count + 1'b1;
			rate_update <= 1'b0;
			if (win_cnt == ctrl_pkg::RATE_WINDOW - 1) begin // Window end
				win_cnt     <= '0;
				gen_rate    <= win_gens + ctrl_pkg::RATE_W'(gen_done);
				win_gens    <= '0;
				rate_update <= 1'b1;
			end else begin
				win_cnt  <= win_cnt + 1'b1;
				win_gens <= win_gens + ctrl_pkg::RATE_W'(gen_done);
			end
		end
	end

endmodule

// ==== hw/life_top.sv ====
// Game of Life core
// Fire button, seed LFSR, generation sequencer, cell banks and statistics

module life_top (
	input  logic                          clk4,
	input  logic                          reset,
	input  logic                          fire_button,
	input  logic                          rd_req,
	input  life_pkg::row_idx_t            rd_row,
	output life_pkg::row_t                rd_data,
	output logic                          ready,
	output logic                          gen_done,
	output logic [ctrl_pkg::COUNT_W-1:0] gen_count,
	output logic [ctrl_pkg::RATE_W-1:0]  gen_rate,
	output logic                          rate_update
);

	logic               step;     // One generation
	logic               run;      // Back-to-back generations
	logic               seed_adv;
	life_pkg::row_t     seed_row;
	life_pkg::row_idx_t rd_center;
	logic               wr_en;
	life_pkg::row_idx_t wr_row;
	logic               wr_seed;
	logic               bank_sel; // Active bank

	button_debounce _firedb (
		.clk4( clk4 ), .reset( reset ),
		.fire_button( fire_button ),
		.step( step ),
		.run ( run  )
	);

	seed_lfsr _seed (
		.clk4( clk4 ), .reset( reset ),
		.seed_adv( seed_adv ),
		.seed_row( seed_row )
	);

	gen_sequencer _seq (
		.clk4( clk4 ), .reset( reset ),
		.step( step ), .run( run ),
		.seed_adv ( seed_adv  ),
		.rd_center( rd_center ),
		.wr_en    ( wr_en     ),
		.wr_row   ( wr_row    ),
		.wr_seed  ( wr_seed   ),
		.bank_sel ( bank_sel  ),
		.ready    ( ready     ),
		.gen_done ( gen_done  )
	);

	cell_array _cells (
		.clk4( clk4 ), .reset( reset ),
		.rd_center( rd_center ), .bank_sel( bank_sel ),
		.wr_en( wr_en ), .wr_row( wr_row ), .wr_seed( wr_seed ), .seed_row( seed_row ),
		.rd_req( rd_req ), .rd_row( rd_row ), .rd_data( rd_data ) // Video fetch replacement
	);

	gen_stats _stats (
		.clk4( clk4 ), .reset( reset ),
		.gen_done   ( gen_done    ),
		.gen_count  ( gen_count   ),
		.gen_rate   ( gen_rate    ),
		.rate_update( rate_update )
	);

endmodule

// ==== test/life_model.svh ====
// Reference model of the life core
// LFSR seed rows, B3/S23 step on the torus and the expected generation count
`ifndef LIFE_MODEL_SVH
`define LIFE_MODEL_SVH

life_pkg::row_t exp_grid [life_pkg::GRID_H]; // Expected active bank
int unsigned    exp_gens;                     // Expected gen_count

// One Fibonacci step, feedback enters at the top
function automatic logic [life_pkg::LFSR_W-1:0] lfsr_step(
	input logic [life_pkg::LFSR_W-1:0] s
);
	logic fb;
	fb = 1'b0;
	for (int b = 0; b < life_pkg::LFSR_W; b++) begin
		if (life_pkg::LFSR_TAPS[b]) fb = fb ^ s[b]; // Tapped bits only
	end
	return {fb, s[life_pkg::LFSR_W-1:1]};
endfunction

// Row r holds the state after r+1 steps
task automatic seed_grid();
	logic [life_pkg::LFSR_W-1:0] s;
	s = life_pkg::LFSR_SEED;
	for (int r = 0; r < life_pkg::GRID_H; r++) begin
		s = lfsr_step(s);
		exp_grid[r] = life_pkg::row_t'(s);
	end
	exp_gens = 0;
endtask

// One generation, eight neighbors with wrap in both directions
task automatic advance_grid();
	life_pkg::row_t nxt [life_pkg::GRID_H];
	int n;
	int rr;
	int cc;
	for (int r = 0; r < life_pkg::GRID_H; r++) begin
		for (int c = 0; c < life_pkg::GRID_W; c++) begin
			n = 0;
			for (int dr = -1; dr <= 1; dr++) begin
				for (int dc = -1; dc <= 1; dc++) begin
					if (dr != 0 || dc != 0) begin
						rr = (r + dr + life_pkg::GRID_H) % life_pkg::GRID_H;
						cc = (c + dc + life_pkg::GRID_W) % life_pkg::GRID_W;
						n  = n + exp_grid[rr][cc];
					end
				end
			end
			nxt[r][c] = (n == 3) || (exp_grid[r][c] && n == 2); // Birth or survival
		end
	end
	exp_grid = nxt;
	exp_gens++;
endtask

`endif

// ==== test/tb_life_top.sv ====
// Testbench for the Game of Life core
// Random button presses from a fixed seed, checked against the grid model

module tb_life_top;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int GEN_CYCLES = life_pkg::GRID_H + life_pkg::RULE_LAT + 1; // go to gen_done

	logic                         clk4;
	logic                         reset;
	logic                         fire_button;
	logic                         rd_req;
	life_pkg::row_idx_t           rd_row;
	life_pkg::row_t               rd_data;
	logic                         ready;
	logic                         gen_done;
	logic [ctrl_pkg::COUNT_W-1:0] gen_count;
	logic [ctrl_pkg::RATE_W-1:0]  gen_rate;
	logic                         rate_update;

	int          error_count = 0;
	int          test_errors = 0; // Current test only
	int          tests_run   = 0;
	int unsigned done_total  = 0; // gen_done pulses seen
	int unsigned cycle_no    = 0;
	int unsigned win_gens    = 0; // Pulses since last rate_update
	int unsigned rate_checks = 0;
	int unsigned rate_errors = 0;
	int unsigned done_cycles [$]; // Cycle stamp of each pulse

	`include "life_model.svh"

	life_top uut (
		.clk4       ( clk4        ),
		.reset      ( reset       ),
		.fire_button( fire_button ),
		.rd_req     ( rd_req      ),
		.rd_row     ( rd_row      ),
		.rd_data    ( rd_data     ),
		.ready      ( ready       ),
		.gen_done   ( gen_done    ),
		.gen_count  ( gen_count   ),
		.gen_rate   ( gen_rate    ),
		.rate_update( rate_update )
	);

	initial begin
		clk4 = 1'b0;
		forever #4 clk4 = ~clk4; // 8 ns period
	end

	////////////////////////////////////////////////////////////
	// Monitor, outputs sampled on the falling edge

	always @(negedge clk4) begin
		if (!reset) begin
			cycle_no++;
			if (rate_update) begin // Window closed on the previous cycle
				rate_checks++;
				if (gen_rate != win_gens) begin
					$display("FAILED at %0d ns: gen_rate is %0d, expected %0d",
						$time, gen_rate, win_gens);
					error_count++;
					rate_errors++;
				end
				win_gens = 0;
			end
			if (gen_done) begin
				done_total++;
				win_gens++;
				done_cycles.push_back(cycle_no);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Helpers

	task automatic report_error(input string msg);
		$display("FAILED at %0d ns: %s", $time, msg);
		error_count++;
		test_errors++;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_errors == 0) $display("Test %0d %s: passed", tests_run, name);
		else $display("Test %0d %s: %0d errors", tests_run, name, test_errors);
		test_errors = 0;
	endtask

	task automatic abort_run(input string what);
		$display("Timeout: %s", what);
		$display("Finished with errors");
		$finish;
	endtask

	task automatic wait_ready(input int limit, input string what);
		int n;
		n = 0;
		@(negedge clk4);
		while (!ready) begin
			if (n == limit) abort_run(what);
			n++;
			@(negedge clk4);
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk4);
	endtask

	// Button high for a given number of cycles
	task automatic hold_button(input int cycles);
		@(posedge clk4);
		fire_button <= 1'b1;
		repeat (cycles) @(posedge clk4);
		fire_button <= 1'b0;
	endtask

	// One-cycle request, data sampled after the next edge
	task automatic read_row(input int r, output life_pkg::row_t data);
		@(posedge clk4);
		rd_req <= 1'b1;
		rd_row <= life_pkg::row_idx_t'(r);
		@(posedge clk4);
		rd_req <= 1'b0;
		@(negedge clk4);
		data = rd_data;
	endtask

	task automatic check_grid(input string tag);
		life_pkg::row_t got;
		for (int r = 0; r < life_pkg::GRID_H; r++) begin
			read_row(r, got);
			if (got !== exp_grid[r])
				report_error($sformatf("%s row %0d is %h, expected %h", tag, r, got, exp_grid[r]));
		end
	endtask

	task automatic check_count();
		if (gen_count !== exp_gens)
			report_error($sformatf("gen_count is %0d, expected %0d", gen_count, exp_gens));
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		int          press_len;
		int          pulses;
		int          hold_len;
		int unsigned base;
		int unsigned n_done;
		int unsigned checks_base;
		int unsigned rate_err_base;

		void'($urandom(32'h1ec5_7157));
		reset       = 1'b1;
		fire_button = 1'b0;
		rd_req      = 1'b0;
		rd_row      = '0;
		repeat (8) @(posedge clk4);
		reset <= 1'b0;

		// Seed rows after power-up
		seed_grid();
		wait_ready(ctrl_pkg::INIT_WAIT + life_pkg::GRID_H + 20, "ready did not rise after reset");
		check_grid("seed");
		check_count();
		end_test("seed");

		// Short press, one generation
		base      = done_total;
		press_len = $urandom_range(ctrl_pkg::DB_LONG - 20, ctrl_pkg::DB_PRESS + 4);
		hold_button(press_len);
		idle_cycles(ctrl_pkg::DB_RELEASE + 8);
		wait_ready(2 * GEN_CYCLES, "ready did not return after a short press");
		if (done_total - base != 1)
			report_error($sformatf("short press gave %0d generations", done_total - base));
		advance_grid();
		check_count();
		check_grid("step");
		end_test("single_step");

		// Glitches shorter than the press time
		base   = done_total;
		pulses = $urandom_range(12, 6);
		for (int i = 0; i < pulses; i++) begin
			idle_cycles($urandom_range(40, 3));
			hold_button($urandom_range(ctrl_pkg::DB_PRESS - 1, 1));
		end
		idle_cycles(ctrl_pkg::DB_RELEASE + 8);
		if (done_total != base) report_error("glitch pulses started a generation");
		if (!ready) report_error("ready low after glitch pulses");
		check_count();
		check_grid("glitch");
		end_test("glitch");

		// Long hold, run mode for more than one rate window
		base          = done_total;
		checks_base   = rate_checks;
		rate_err_base = rate_errors;
		done_cycles.delete();
		hold_len = ctrl_pkg::DB_LONG + 800 + $urandom_range(400, 0);
		hold_button(hold_len);
		idle_cycles(ctrl_pkg::DB_RELEASE + 8);
		wait_ready(2 * GEN_CYCLES, "ready did not return after run mode");
		idle_cycles(GEN_CYCLES);
		if (!ready) report_error("ready dropped after run mode ended");
		n_done = done_total - base;

		// Pulse 0 is the step, pulse 1 the first run generation
		if (done_cycles.size() < 3) report_error("too few generations in run mode");
		for (int i = 2; i < done_cycles.size(); i++) begin
			if (done_cycles[i] - done_cycles[i-1] != GEN_CYCLES)
				report_error($sformatf("gen_done spacing %0d, expected %0d",
					done_cycles[i] - done_cycles[i-1], GEN_CYCLES));
		end
		end_test("latency");

		repeat (n_done) advance_grid();
		check_count();
		check_grid("run");
		end_test("run_mode");

		// Rate values are checked by the monitor as they arrive
		if (rate_checks == checks_base) report_error("no rate_update seen during run mode");
		test_errors += rate_errors - rate_err_base;
		end_test("rate");

		$display("Tests run: %0d, errors: %0d", tests_run, error_count);
		if (error_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+test
hw/life_pkg.sv
hw/ctrl_pkg.sv
hw/stage_delay.sv
hw/button_debounce.sv
hw/seed_lfsr.sv
hw/gen_sequencer.sv
hw/cell_array.sv
hw/gen_stats.sv
hw/life_top.sv
test/tb_life_top.sv
